/* rtl/cfg_regs.sv */
/*
 * Configuration registers: one-shot length, period,
 * PWM width and output enable and invert masks
 */
`timescale 1ns/1ps
`default_nettype none

module cfg_regs (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             load,
  input  pulse_cfg_pkg::cfg_op_e           opcode,
  input  logic [pulse_cfg_pkg::CNT_W-1:0]  data,
  output logic [pulse_cfg_pkg::CNT_W-1:0]  shot_len,
  output logic [pulse_cfg_pkg::CNT_W-1:0]  period,
  output logic [pulse_cfg_pkg::CNT_W-1:0]  pwm_width,
  output logic [pulse_cfg_pkg::CHAN_N-1:0] en_mask,
  output logic [pulse_cfg_pkg::CHAN_N-1:0] inv_mask
);

  import pulse_cfg_pkg::*;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      shot_len  <= '0;
      period    <= '0;
      pwm_width <= '0;
      en_mask   <= '0;
      inv_mask  <= '0;
    end
    else if (load)
    begin
      case (opcode)
        OP_SHOT_LEN:  shot_len  <= data;
        OP_PERIOD:    period    <= data;
        OP_PWM_WIDTH: pwm_width <= data;
        OP_OUT_CTRL:
        begin
          en_mask  <= data[EN_LSB +: CHAN_N];
          inv_mask <= data[INV_LSB +: CHAN_N];
        end
        default: ;
      endcase
    end
  end

  a_opcode_known: assert property (
    @(posedge clk) disable iff (rst) load |-> !$isunknown(opcode)
  );

endmodule

`default_nettype wire

/* rtl/edge_sync.sv */
/*
 * Synchronizer and rising-edge detector for the trigger,
 * start and stop pins
 */
`timescale 1ns/1ps
`default_nettype none

module edge_sync (
  input  logic clk,
  input  logic rst,
  input  logic trig_pin,
  input  logic start_pin,
  input  logic stop_pin,
  output logic trig_pulse,
  output logic start_pulse,
  output logic stop_pulse
);

  localparam int PIN_N = 3;

  logic [PIN_N-1:0] pins;
  logic [PIN_N-1:0] sync1;
  logic [PIN_N-1:0] sync2;
  logic [PIN_N-1:0] sync3;
  logic [PIN_N-1:0] pulse_q;

  assign pins = {stop_pin, start_pin, trig_pin};

  // Two flops for metastability, third holds the previous sample
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      sync1   <= '0;
      sync2   <= '0;
      sync3   <= '0;
      pulse_q <= '0;
    end
    else
    begin
      sync1   <= pins;
      sync2   <= sync1;
      sync3   <= sync2;
      pulse_q <= sync2 & ~sync3;
    end
  end

  assign trig_pulse  = pulse_q[0];
  assign start_pulse = pulse_q[1];
  assign stop_pulse  = pulse_q[2];

endmodule

`default_nettype wire

/* rtl/one_shot.sv */
/*
 * Retriggerable one-shot, pulse of shot_len+1 cycles
 * starting the cycle after a trigger
 */
`timescale 1ns/1ps
`default_nettype none

module one_shot (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            trig_pulse,
  input  logic [pulse_cfg_pkg::CNT_W-1:0] shot_len,
  output logic                            shot_out
);

  import pulse_cfg_pkg::*;
  import pulse_state_pkg::*;

  gen_state_e       state;
  logic [CNT_W-1:0] cnt;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state    <= ST_IDLE;
      cnt      <= '0;
      shot_out <= 1'b0;
    end
    else if (trig_pulse)
    begin
      // A trigger always restarts the count
      state    <= ST_RUN;
      cnt      <= '0;
      shot_out <= 1'b1;
    end
    else if (state == ST_RUN)
    begin
      if (cnt >= shot_len)
      begin
        state    <= ST_IDLE;
        cnt      <= '0;
        shot_out <= 1'b0;
      end
      else
        cnt <= cnt + 1'b1;
    end
  end

  a_out_in_run: assert property (
    @(posedge clk) disable iff (rst) shot_out |-> state == ST_RUN
  );

endmodule

`default_nettype wire

/* rtl/periodic_pulse.sv */
/*
 * Periodic tick generator, one-cycle tick every period+1
 * cycles while running
 */
`timescale 1ns/1ps
`default_nettype none

module periodic_pulse (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            start_pulse,
  input  logic                            stop_pulse,
  input  logic [pulse_cfg_pkg::CNT_W-1:0] period,
  output logic                            tick_out
);

  import pulse_cfg_pkg::*;
  import pulse_state_pkg::*;

  gen_state_e       state;
  logic [CNT_W-1:0] cnt;
  logic             wrap;

  // Compare with >= so a shortened period still wraps
  assign wrap     = (state == ST_RUN) && (cnt >= period);
  assign tick_out = wrap;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= ST_IDLE;
      cnt   <= '0;
    end
    else if (stop_pulse)
    begin
      state <= ST_IDLE;
      cnt   <= '0;
    end
    else if (start_pulse)
    begin
      state <= ST_RUN;
      cnt   <= '0;
    end
    else if (wrap)
      cnt <= '0;
    else if (state == ST_RUN)
      cnt <= cnt + 1'b1;
  end

  // Period 0 means a tick every cycle
  a_tick_single: assert property (
    @(posedge clk) disable iff (rst) tick_out ##1 (period != '0) |-> !tick_out
  );

endmodule

`default_nettype wire

/* rtl/pulse_cfg_pkg.sv */
/*
 * Register map of the pulse timer: counter width, channel count,
 * channel indices and configuration opcodes
 */
`default_nettype none

package pulse_cfg_pkg;

  localparam int CNT_W = 8;
  localparam int CHAN_N = 3;

  localparam int CH_SHOT = 0;
  localparam int CH_TICK = 1;
  localparam int CH_PWM = 2;

  // Field positions in the OP_OUT_CTRL data word
  localparam int EN_LSB = 0;
  localparam int INV_LSB = 4;

  typedef enum logic [1:0] {
    OP_SHOT_LEN  = 2'd0,
    OP_PERIOD    = 2'd1,
    OP_PWM_WIDTH = 2'd2,
    OP_OUT_CTRL  = 2'd3
  } cfg_op_e;

endpackage

`default_nettype wire

/* rtl/pulse_out_stage.sv */
/*
 * Output stage that masks and inverts the generator channels
 * and registers them onto the pins
 */
`timescale 1ns/1ps
`default_nettype none

module pulse_out_stage (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [pulse_cfg_pkg::CHAN_N-1:0] chan_in,
  input  logic [pulse_cfg_pkg::CHAN_N-1:0] en_mask,
  input  logic [pulse_cfg_pkg::CHAN_N-1:0] inv_mask,
  output logic                             shot_pin,
  output logic                             tick_pin,
  output logic                             pwm_pin
);

  import pulse_cfg_pkg::*;

  logic [CHAN_N-1:0] pin_q;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      pin_q <= '0;
    else
      pin_q <= (chan_in & en_mask) ^ inv_mask;
  end

  assign shot_pin = pin_q[CH_SHOT];
  assign tick_pin = pin_q[CH_TICK];
  assign pwm_pin  = pin_q[CH_PWM];

endmodule

`default_nettype wire

/* rtl/pulse_state_pkg.sv */
/*
 * Generator state encoding shared by the one-shot,
 * periodic tick and PWM generators
 */
`default_nettype none

package pulse_state_pkg;

  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_RUN  = 1'b1
  } gen_state_e;

endpackage

`default_nettype wire

/* rtl/pulse_timer_top.sv */
/*
 * Pulse timer top: input synchronizer, configuration registers,
 * the three generators and the output stage
 */
`timescale 1ns/1ps
`default_nettype none

module pulse_timer_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            trig_pin,
  input  logic                            start_pin,
  input  logic                            stop_pin,
  input  logic                            load,
  input  pulse_cfg_pkg::cfg_op_e          opcode,
  input  logic [pulse_cfg_pkg::CNT_W-1:0] data,
  output logic                            shot_pin,
  output logic                            tick_pin,
  output logic                            pwm_pin
);

  import pulse_cfg_pkg::*;

  logic              trig_pulse;
  logic              start_pulse;
  logic              stop_pulse;
  logic [CNT_W-1:0]  shot_len;
  logic [CNT_W-1:0]  period;
  logic [CNT_W-1:0]  pwm_width;
  logic [CHAN_N-1:0] en_mask;
  logic [CHAN_N-1:0] inv_mask;
  logic [CHAN_N-1:0] chan;

  edge_sync u_edge_sync (
    .clk         (clk),
    .rst         (rst),
    .trig_pin    (trig_pin),
    .start_pin   (start_pin),
    .stop_pin    (stop_pin),
    .trig_pulse  (trig_pulse),
    .start_pulse (start_pulse),
    .stop_pulse  (stop_pulse)
  );

  cfg_regs u_cfg_regs (
    .clk       (clk),
    .rst       (rst),
    .load      (load),
    .opcode    (opcode),
    .data      (data),
    .shot_len  (shot_len),
    .period    (period),
    .pwm_width (pwm_width),
    .en_mask   (en_mask),
    .inv_mask  (inv_mask)
  );

  one_shot u_one_shot (
    .clk        (clk),
    .rst        (rst),
    .trig_pulse (trig_pulse),
    .shot_len   (shot_len),
    .shot_out   (chan[CH_SHOT])
  );

  periodic_pulse u_periodic_pulse (
    .clk         (clk),
    .rst         (rst),
    .start_pulse (start_pulse),
    .stop_pulse  (stop_pulse),
    .period      (period),
    .tick_out    (chan[CH_TICK])
  );

  // PWM shares start and stop with the tick generator
  pwm_gen u_pwm_gen (
    .clk         (clk),
    .rst         (rst),
    .start_pulse (start_pulse),
    .stop_pulse  (stop_pulse),
    .period      (period),
    .pwm_width   (pwm_width),
    .pwm_out     (chan[CH_PWM])
  );

  pulse_out_stage u_pulse_out_stage (
    .clk      (clk),
    .rst      (rst),
    .chan_in  (chan),
    .en_mask  (en_mask),
    .inv_mask (inv_mask),
    .shot_pin (shot_pin),
    .tick_pin (tick_pin),
    .pwm_pin  (pwm_pin)
  );

endmodule

`default_nettype wire

/* rtl/pwm_gen.sv */
/*
 * PWM generator with frames of period+1 cycles and a high
 * width latched at every frame start
 */
`timescale 1ns/1ps
`default_nettype none

module pwm_gen (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            start_pulse,
  input  logic                            stop_pulse,
  input  logic [pulse_cfg_pkg::CNT_W-1:0] period,
  input  logic [pulse_cfg_pkg::CNT_W-1:0] pwm_width,
  output logic                            pwm_out
);

  import pulse_cfg_pkg::*;
  import pulse_state_pkg::*;

  gen_state_e       state;
  logic [CNT_W-1:0] fcnt;
  logic [CNT_W-1:0] fcnt_nxt;
  logic [CNT_W-1:0] per_lat;
  logic [CNT_W-1:0] width_lat;
  logic             frame_end;

  assign frame_end = (state == ST_RUN) && (fcnt >= per_lat);
  assign fcnt_nxt  = fcnt + 1'b1;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state     <= ST_IDLE;
      fcnt      <= '0;
      per_lat   <= '0;
      width_lat <= '0;
      pwm_out   <= 1'b0;
    end
    else if (stop_pulse)
    begin
      state   <= ST_IDLE;
      fcnt    <= '0;
      pwm_out <= 1'b0;
    end
    else if (start_pulse || frame_end)
    begin
      // New frame picks up the current settings
      state     <= ST_RUN;
      fcnt      <= '0;
      per_lat   <= period;
      width_lat <= pwm_width;
      pwm_out   <= (pwm_width != '0);
    end
    else if (state == ST_RUN)
    begin
      fcnt    <= fcnt_nxt;
      pwm_out <= (fcnt_nxt < width_lat);
    end
  end

  a_zero_width_low: assert property (
    @(posedge clk) disable iff (rst) (width_lat == '0) |-> !pwm_out
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Compile and run the pulse timer testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f \
  --top-module tb_pulse_timer -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_pulse_timer" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* sim.f */
rtl/pulse_cfg_pkg.sv
rtl/pulse_state_pkg.sv
rtl/edge_sync.sv
rtl/cfg_regs.sv
rtl/one_shot.sv
rtl/periodic_pulse.sv
rtl/pwm_gen.sv
rtl/pulse_out_stage.sv
rtl/pulse_timer_top.sv
sim/tb_pulse_timer.sv

/* sim/tb_pulse_timer.sv */
/*
 * Directed testbench for the pulse timer: idle pins, one-shot width
 * and retrigger, periodic ticks, PWM duty and output control
 */
`timescale 1ns/1ps
`default_nettype none

module tb_pulse_timer;

  import pulse_cfg_pkg::*;

  localparam int TIMEOUT_CYCLES = 20000;
  localparam int WAIT_LIMIT = 600;
  localparam int PIN_TRIG = 0;
  localparam int PIN_START = 1;
  localparam int PIN_STOP = 2;

  logic             clk;
  logic             rst;
  logic             trig_pin;
  logic             start_pin;
  logic             stop_pin;
  logic             load;
  cfg_op_e          opcode;
  logic [CNT_W-1:0] data;
  logic             shot_pin;
  logic             tick_pin;
  logic             pwm_pin;

  int cycles;
  int errors;
  int test_err_start;
  int tests_run;
  int tests_failed;
  int seed_ret;

  pulse_timer_top u_dut (
    .clk       (clk),
    .rst       (rst),
    .trig_pin  (trig_pin),
    .start_pin (start_pin),
    .stop_pin  (stop_pin),
    .load      (load),
    .opcode    (opcode),
    .data      (data),
    .shot_pin  (shot_pin),
    .tick_pin  (tick_pin),
    .pwm_pin   (pwm_pin)
  );

  always #4 clk = ~clk;

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, a test never finished", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic steps(input int n);
    repeat (n) step();
  endtask

  function automatic int pin_val(input int ch);
    case (ch)
      CH_SHOT: return int'(shot_pin);
      CH_TICK: return int'(tick_pin);
      default: return int'(pwm_pin);
    endcase
  endfunction

  function automatic string chan_name(input int ch);
    case (ch)
      CH_SHOT: return "shot_pin";
      CH_TICK: return "tick_pin";
      default: return "pwm_pin";
    endcase
  endfunction

  task automatic check(input string name, input int got, input int exp);
    if (got !== exp)
    begin
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_all_pins(input int exp);
    for (int ch = 0; ch < CHAN_N; ch++)
      check(chan_name(ch), pin_val(ch), exp);
  endtask

  task automatic start_test();
    test_err_start = errors;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors != test_err_start)
    begin
      tests_failed++;
      $display("%s: failed", name);
    end
    else
      $display("%s: ok", name);
  endtask

  // Config word is taken on the edge that ends this call
  task automatic write_cfg(input cfg_op_e op, input int value);
    load = 1'b1;
    opcode = op;
    data = CNT_W'(value);
    step();
    load = 1'b0;
  endtask

  task automatic set_pin(input int which, input logic level);
    case (which)
      PIN_TRIG:  trig_pin = level;
      PIN_START: start_pin = level;
      default:   stop_pin = level;
    endcase
  endtask

  task automatic pulse_pin(input int which);
    set_pin(which, 1'b1);
    step();
    set_pin(which, 1'b0);
  endtask

  task automatic wait_rise(input int ch, output bit seen);
    int prev;
    int n;
    seen = 1'b0;
    prev = pin_val(ch);
    for (n = 0; n < WAIT_LIMIT && !seen; n++)
    begin
      step();
      seen = (prev == 0) && (pin_val(ch) == 1);
      prev = pin_val(ch);
    end
    if (!seen)
    begin
      $display("%s never went high within %0d cycles", chan_name(ch), WAIT_LIMIT);
      errors++;
    end
  endtask

  // Cycles the pin stays at level, starting with the current sample
  task automatic count_level(input int ch, input int level, output int n);
    n = 0;
    while (pin_val(ch) == level && n < WAIT_LIMIT)
    begin
      n++;
      step();
    end
  endtask

  task automatic test_idle();
    start_test();
    repeat (20)
    begin
      check_all_pins(0);
      step();
    end
    finish_test("idle after reset");
  endtask

  task automatic test_shot_width(input int len);
    bit seen;
    int width;
    start_test();
    write_cfg(OP_OUT_CTRL, 1 << CH_SHOT);
    write_cfg(OP_SHOT_LEN, len);
    pulse_pin(PIN_TRIG);
    wait_rise(CH_SHOT, seen);
    if (seen)
    begin
      count_level(CH_SHOT, 1, width);
      check("shot_pin high cycles", width, len + 1);
    end
    finish_test($sformatf("one-shot width L=%0d", len));
  endtask

  task automatic test_retrigger(input int len, input int gap);
    bit seen;
    int width;
    start_test();
    write_cfg(OP_SHOT_LEN, len);
    fork
      begin
        pulse_pin(PIN_TRIG);
        steps(gap - 1);
        pulse_pin(PIN_TRIG);
      end
      begin
        wait_rise(CH_SHOT, seen);
        if (seen)
          count_level(CH_SHOT, 1, width);
      end
    join
    if (seen)
      check("shot_pin retrigger high cycles", width, gap + len + 1);
    finish_test($sformatf("one-shot retrigger L=%0d k=%0d", len, gap));
  endtask

  task automatic test_ticks(input int per);
    bit seen;
    int width;
    int gap;
    int i;
    start_test();
    write_cfg(OP_OUT_CTRL, 1 << CH_TICK);
    write_cfg(OP_PERIOD, per);
    pulse_pin(PIN_START);
    wait_rise(CH_TICK, seen);
    for (i = 0; i < 4 && seen; i++)
    begin
      count_level(CH_TICK, 1, width);
      count_level(CH_TICK, 0, gap);
      check("tick_pin high cycles", width, 1);
      check("tick_pin rise spacing", width + gap, per + 1);
    end
    pulse_pin(PIN_STOP);
    // Let ticks already in the sync and output pipe drain
    steps(6);
    for (i = 0; i < 2 * (per + 1); i++)
    begin
      check("tick_pin after stop", pin_val(CH_TICK), 0);
      step();
    end
    finish_test($sformatf("periodic ticks period=%0d", per));
  endtask

  task automatic test_pwm(input int frame_per, input int width);
    int frames;
    int high;
    int exp;
    int i;
    start_test();
    write_cfg(OP_OUT_CTRL, 1 << CH_PWM);
    write_cfg(OP_PERIOD, frame_per);
    write_cfg(OP_PWM_WIDTH, width);
    pulse_pin(PIN_START);
    steps(8);
    frames = 4;
    high = 0;
    // Any window of whole frames holds the same high count
    for (i = 0; i < frames * (frame_per + 1); i++)
    begin
      high += pin_val(CH_PWM);
      step();
    end
    exp = frames * ((width < frame_per + 1) ? width : frame_per + 1);
    check("pwm_pin high cycles", high, exp);
    pulse_pin(PIN_STOP);
    steps(8);
    finish_test($sformatf("pwm duty F=%0d W=%0d", frame_per, width));
  endtask

  task automatic test_out_ctrl();
    start_test();
    // All channels disabled and inverted
    write_cfg(OP_OUT_CTRL, 'h70);
    steps(2);
    check_all_pins(1);
    write_cfg(OP_SHOT_LEN, 3);
    write_cfg(OP_PERIOD, 2);
    write_cfg(OP_PWM_WIDTH, 1);
    pulse_pin(PIN_TRIG);
    pulse_pin(PIN_START);
    repeat (30)
    begin
      check_all_pins(1);
      step();
    end
    pulse_pin(PIN_STOP);
    write_cfg(OP_OUT_CTRL, 0);
    steps(8);
    check_all_pins(0);
    finish_test("output enable and invert");
  endtask

  initial
  begin
    int len;
    int gap;
    clk = 1'b0;
    rst = 1'b1;
    trig_pin = 1'b0;
    start_pin = 1'b0;
    stop_pin = 1'b0;
    load = 1'b0;
    opcode = OP_SHOT_LEN;
    data = '0;
    cycles = 0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    seed_ret = $urandom(32'hca7a);
    steps(4);
    rst = 1'b0;

    test_idle();
    test_shot_width(0);
    test_shot_width(5);
    test_shot_width(1 + $urandom % 40);
    len = 6 + $urandom % 20;
    gap = 2 + $urandom % (len - 1);
    test_retrigger(len, gap);
    test_ticks(3);
    test_ticks(1 + $urandom % 30);
    test_pwm(7, 3);
    test_pwm(7, 0);
    test_pwm(5, 9);
    test_pwm(9, 1 + $urandom % 9);
    test_out_ctrl();

    $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire
